// File: Makefile
# Verilator build and run of the fetch front end testbench

SOURCES := $(wildcard rtl/*.sv verification/*.sv)
BINARY  := obj_dir/Vfetch_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): sim.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fetch_tb -f sim.f

# the log decides pass or fail
run: $(BINARY)
	./$(BINARY) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // architectural word, one rv32 instruction
    parameter int xlen = 32;

    // cache line and wishbone data width, two instructions per line
    parameter int line_bits = 64;

    // bytes per line and the offset bits that address them
    parameter int line_bytes       = line_bits / 8;
    parameter int line_offset_bits = $clog2(line_bytes); // 3 for a 64-bit line

    // wishbone master address is a full byte address
    parameter int wb_adr_bits = xlen;
    parameter int wb_sel_bits = line_bytes; // one select per byte lane

    // next-pc sources, one request bit each
    parameter int num_sources = 4;

    // bit positions in the request vector
    // the highest bit has the highest priority
    parameter int sel_branch = 3; // resolved branch from execute
    parameter int sel_rob    = 2; // target from the reorder buffer
    parameter int sel_pred   = 1; // predictor guess
    parameter int sel_seq    = 0; // sequential pc + 4

endpackage

`default_nettype wire

// File: rtl/fetch_top.sv
`default_nettype none

// fetch front end, fetch unit plus its instruction cache
module fetch_top import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc  = '0,
    parameter int              num_lines = 16
) (
    input  wire logic                   clock,
    input  wire logic                   reset,

    // redirects
    input  wire logic [xlen-1:0]        branch_pc,
    input  wire logic                   branch_req,
    input  wire logic [xlen-1:0]        rob_pc,
    input  wire logic                   rob_req,
    input  wire logic [xlen-1:0]        pred_pc,
    input  wire logic                   pred_req,

    input  wire logic                   decode_stall,

    // to decode
    output logic      [xlen-1:0]        fetch_inst,
    output logic      [xlen-1:0]        fetch_pc,
    output logic      [xlen-1:0]        fetch_npc,
    output logic                        fetch_valid,

    // wishbone classic master
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic      [wb_adr_bits-1:0] wb_adr,
    output logic      [wb_sel_bits-1:0] wb_sel,
    input  wire logic [line_bits-1:0]   wb_dat_i,
    input  wire logic                   wb_ack
);

    logic [xlen-1:0]      line_addr; // pc with the line offset cleared
    logic [line_bits-1:0] line_data;
    logic                 hit;

    fetch_unit #(
        .reset_pc     (reset_pc)
    ) fetch_unit_inst (
        .clock        (clock),
        .reset        (reset),
        .decode_stall (decode_stall),
        .branch_pc    (branch_pc),
        .branch_req   (branch_req),
        .rob_pc       (rob_pc),
        .rob_req      (rob_req),
        .pred_pc      (pred_pc),
        .pred_req     (pred_req),
        .line_data    (line_data),
        .hit          (hit),
        .line_addr    (line_addr),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .fetch_npc    (fetch_npc),
        .fetch_valid  (fetch_valid)
    );

    icache #(
        .num_lines    (num_lines)
    ) icache_inst (
        .clock        (clock),
        .reset        (reset),
        .line_addr    (line_addr),
        .line_data    (line_data),
        .hit          (hit),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack)
    );

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`default_nettype none

// pc register and next-pc choice
// the cache answers in the same cycle, so a hit hands the instruction out at once
module fetch_unit import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 decode_stall, // decode cannot take an instruction

    // redirect sources
    input  wire logic [xlen-1:0]      branch_pc,
    input  wire logic                 branch_req,
    input  wire logic [xlen-1:0]      rob_pc,
    input  wire logic                 rob_req,
    input  wire logic [xlen-1:0]      pred_pc,
    input  wire logic                 pred_req,

    // icache lookup
    input  wire logic [line_bits-1:0] line_data,
    input  wire logic                 hit,
    output logic      [xlen-1:0]      line_addr,

    // toward decode
    output logic      [xlen-1:0]      fetch_inst,
    output logic      [xlen-1:0]      fetch_pc,
    output logic      [xlen-1:0]      fetch_npc,
    output logic                      fetch_valid
);

    logic [xlen-1:0]        pc_q;      // pc being fetched
    logic [xlen-1:0]        next_pc;
    logic [num_sources-1:0] req;
    logic [num_sources-1:0] gnt;
    logic                   grant_any; // no grant means the pc holds
    logic                   accept;    // decode takes the instruction this cycle

    assign accept = fetch_valid & ~decode_stall;

    always_comb begin
        req             = '0;
        req[sel_branch] = branch_req;
        req[sel_rob]    = rob_req;
        req[sel_pred]   = pred_req;
        req[sel_seq]    = accept; // only step on once the current one is taken
    end

    priority_select #(
        .width (num_sources)
    ) next_pc_select (
        .req   (req),
        .gnt   (gnt),
        .any   (grant_any)
    );

    // gnt is one-hot, so the order here does not matter
    always_comb begin
        next_pc = pc_q;
        if (gnt[sel_branch]) begin
            next_pc = branch_pc;
        end else if (gnt[sel_rob]) begin
            next_pc = rob_pc;
        end else if (gnt[sel_pred]) begin
            next_pc = pred_pc;
        end else if (gnt[sel_seq]) begin
            next_pc = fetch_npc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= reset_pc;
        end else if (grant_any) begin
            pc_q <= next_pc; // redirects load even on a miss or a stall
        end
    end

    // the cache works on whole lines
    assign line_addr = {pc_q[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}};

    // pc bit 2 picks the word inside the 64-bit line, lower word in bits 31:0
    assign fetch_inst = pc_q[2] ? line_data[line_bits-1:xlen] : line_data[xlen-1:0];

    assign fetch_pc    = pc_q;
    assign fetch_npc   = pc_q + 32'd4;
    assign fetch_valid = hit; // all lines invalid after reset, so this starts low

endmodule

`default_nettype wire

// File: rtl/icache.sv
`default_nettype none

// direct-mapped instruction cache
// lookup is combinational, a miss is filled by one wishbone classic read
module icache import fetch_pkg::*; #(
    parameter int num_lines = 16 // power of two
) (
    input  wire logic                   clock,
    input  wire logic                   reset,

    // lookup from fetch
    input  wire logic [xlen-1:0]        line_addr,
    output logic      [line_bits-1:0]   line_data,
    output logic                        hit,

    // wishbone classic master, read only
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic      [wb_adr_bits-1:0] wb_adr,
    output logic      [wb_sel_bits-1:0] wb_sel,
    input  wire logic [line_bits-1:0]   wb_dat_i,
    input  wire logic                   wb_ack
);

    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits   = xlen - index_bits - line_offset_bits;
    localparam int fill_bits  = xlen - line_offset_bits; // line number, offset dropped

    typedef enum logic {
        idle,
        busy
    } fill_state_t;

    fill_state_t            state;

    logic [num_lines-1:0]   valid_q;               // one per line, cleared by reset
    logic [tag_bits-1:0]    tag_mem  [num_lines];
    logic [line_bits-1:0]   data_mem [num_lines];

    logic [index_bits-1:0]  index;                 // lookup side
    logic [tag_bits-1:0]    tag;
    logic [fill_bits-1:0]   fill_line;             // line being filled
    logic [index_bits-1:0]  fill_index;
    logic [tag_bits-1:0]    fill_tag;
    logic                   start_fill;
    logic                   fill_done;

    // lookup
    assign index = line_addr[line_offset_bits +: index_bits];
    assign tag   = line_addr[xlen-1 -: tag_bits];

    assign hit       = valid_q[index] && (tag_mem[index] == tag);
    assign line_data = data_mem[index];

    // fill side takes its index and tag from the latched line
    assign fill_index = fill_line[index_bits-1:0];
    assign fill_tag   = fill_line[fill_bits-1 -: tag_bits];

    assign start_fill = (state == idle) && !hit;  // bus cycle opens at the next edge
    assign fill_done  = (state == busy) && wb_ack;

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= idle;
            valid_q <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start_fill) begin
                        state <= busy;
                    end
                end
                busy: begin
                    if (wb_ack) begin
                        state              <= idle; // cyc drops in the cycle after ack
                        valid_q[fill_index] <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // miss address, held for the whole bus cycle
    always_ff @(posedge clock) begin
        if (start_fill) begin
            fill_line <= line_addr[xlen-1:line_offset_bits];
        end
    end

    // line and tag written on the ack edge, hit shows the cycle after
    always_ff @(posedge clock) begin
        if (fill_done) begin
            data_mem[fill_index] <= wb_dat_i;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

    // a redirect mid fill does not abort, the line still lands in the cache
    assign wb_cyc = (state == busy);
    assign wb_stb = (state == busy); // single transfer, stb follows cyc
    assign wb_we  = 1'b0;
    assign wb_sel = '1;              // always the full line
    assign wb_adr = {fill_line, {line_offset_bits{1'b0}}};

endmodule

`default_nettype wire

// File: rtl/priority_select.sv
`default_nettype none

// fixed priority arbiter, bit width-1 wins over everything below it
module priority_select #(
    parameter int width = 4
) (
    input  wire logic [width-1:0] req, // one bit per requester
    output logic      [width-1:0] gnt, // one-hot, zero when nothing requests
    output logic                  any  // a grant was made
);

    always_comb begin
        gnt = '0;
        // walk upward, so a higher set bit overwrites a lower one
        for (int i = 0; i < width; i++) begin
            if (req[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
            end
        end
    end

    assign any = |req;

endmodule

`default_nettype wire

// File: sim.f
rtl/fetch_pkg.sv
rtl/priority_select.sv
rtl/fetch_unit.sv
rtl/icache.sv
rtl/fetch_top.sv
verification/wb_memory_model.sv
verification/fetch_tb.sv

// File: verification/fetch_tb.sv
`default_nettype none

// fetch front end testbench
// random redirects and stalls against a pc and cache model plus wishbone checks
module fetch_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [xlen-1:0] reset_pc      = 32'h0000_0044;
    localparam int              num_lines     = 16;
    localparam int              index_bits    = $clog2(num_lines);
    localparam int              clock_period  = 100;
    localparam int              reset_cycles  = 16;
    localparam int              num_cycles    = 3000;
    localparam int              margin        = 200; // slack cycles for the watchdog
    localparam int              num_behaviors = 6;
    localparam logic [31:0]     lfsr_seed     = 32'h0f38_245c;

    logic                       clock = 1'b0;
    logic                       reset;
    logic [xlen-1:0]            branch_pc;
    logic                       branch_req;
    logic [xlen-1:0]            rob_pc;
    logic                       rob_req;
    logic [xlen-1:0]            pred_pc;
    logic                       pred_req;
    logic                       decode_stall;
    logic [xlen-1:0]            fetch_inst;
    logic [xlen-1:0]            fetch_pc;
    logic [xlen-1:0]            fetch_npc;
    logic                       fetch_valid;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [wb_adr_bits-1:0]     wb_adr;
    logic [wb_sel_bits-1:0]     wb_sel;
    logic [line_bits-1:0]       wb_dat_i;
    logic                       wb_ack;

    logic [31:0]     lfsr_state = lfsr_seed;
    int              checks [num_behaviors] = '{default: 0};
    int              errors [num_behaviors] = '{default: 0};

    // model state
    logic [xlen-1:0] exp_pc;
    logic            model_valid [num_lines];
    logic [xlen-1:0] model_line  [num_lines]; // line address held at each index
    logic            after_reset;
    logic            first_bus;               // no bus cycle seen since reset
    logic            have_prev;
    logic [xlen-1:0] prev_pc;
    logic [xlen-1:0] prev_inst;
    logic [xlen-1:0] prev_adr;
    logic            prev_valid;
    logic            prev_hit;
    logic            prev_hold;               // stalled with no redirect
    logic            prev_cyc;
    logic            prev_ack;

    always #(clock_period / 2) clock = ~clock;

    fetch_top #(
        .reset_pc     (reset_pc),
        .num_lines    (num_lines)
    ) fetch_top_inst (
        .clock        (clock),
        .reset        (reset),
        .branch_pc    (branch_pc),
        .branch_req   (branch_req),
        .rob_pc       (rob_pc),
        .rob_req      (rob_req),
        .pred_pc      (pred_pc),
        .pred_req     (pred_req),
        .decode_stall (decode_stall),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .fetch_npc    (fetch_npc),
        .fetch_valid  (fetch_valid),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack)
    );

    wb_memory_model #(
        .seed     (lfsr_seed ^ 32'h0000_ffff) // its own stream for ack delays
    ) memory_inst (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [xlen-1:0] line_of(input logic [xlen-1:0] a);
        return {a[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}};
    endfunction

    function automatic logic [index_bits-1:0] index_of(input logic [xlen-1:0] a);
        return a[line_offset_bits +: index_bits];
    endfunction

    function automatic logic line_held(input logic [xlen-1:0] a);
        return model_valid[index_of(a)] && (model_line[index_of(a)] == line_of(a));
    endfunction

    function automatic string behavior_name(input int b);
        case (b)
            0:       return "reset and start";
            1:       return "instruction data";
            2:       return "pc sequence and priority";
            3:       return "back-pressure";
            4:       return "cache behavior";
            default: return "bus protocol";
        endcase
    endfunction

    task automatic compare_value(input int b, input string name,
                                 input logic [31:0] got, input logic [31:0] want);
        checks[b]++;
        assert (got === want) else begin
            errors[b]++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    task automatic expect_true(input int b, input logic cond, input string what);
        checks[b]++;
        assert (cond) else begin
            errors[b]++;
            $display("%s at %0t", what, $time);
        end
    endtask

    // rare redirects to word aligned targets inside a 512-byte window
    task drive_random_inputs;
        logic [31:0] r;
        take_bits(5, r);
        branch_req <= (r[4:0] == 5'd0);
        take_bits(7, r);
        branch_pc <= {23'd0, r[6:0], 2'b00};
        take_bits(5, r);
        rob_req <= (r[4:0] == 5'd0);
        take_bits(7, r);
        rob_pc <= {23'd0, r[6:0], 2'b00};
        take_bits(4, r);
        pred_req <= (r[3:0] == 4'd0); // predictor fires a bit more often
        take_bits(7, r);
        pred_pc <= {23'd0, r[6:0], 2'b00};
        take_bits(2, r);
        decode_stall <= (r[1:0] == 2'd0); // about a quarter of the cycles
    endtask

    always @(negedge clock) begin : check_cycle
        logic                   model_hit;
        logic [num_sources-1:0] req_vec;
        logic [xlen-1:0]        next_pc;
        if (reset) begin
            expect_true(0, !fetch_valid && !wb_cyc && !wb_stb,
                        "fetch_valid or the bus was active during reset");
            for (int i = 0; i < num_lines; i++) begin
                model_valid[i] = 1'b0;
            end
            exp_pc      = reset_pc;
            after_reset = 1'b1;
            first_bus   = 1'b1;
            have_prev   = 1'b0;
            prev_cyc    = 1'b0;
            prev_ack    = 1'b0;
        end else begin
            if (after_reset) begin
                expect_true(0, !fetch_valid && !wb_cyc && !wb_stb,
                            "fetch_valid or the bus was active right after reset");
                after_reset = 1'b0;
            end
            expect_true(5, wb_cyc === wb_stb, "cyc and stb differ");
            expect_true(5, wb_we === 1'b0, "we is high on a read-only master");
            expect_true(5, wb_sel === '1, "byte selects are not all ones");
            if (wb_cyc) begin
                expect_true(5, wb_adr[line_offset_bits-1:0] === '0,
                            "bus address is not line aligned");
            end
            if (have_prev && prev_cyc && !prev_ack) begin
                expect_true(5, wb_cyc === 1'b1, "bus cycle ended before ack");
                expect_true(5, wb_adr === prev_adr, "bus address changed before ack");
            end
            if (have_prev && prev_ack) begin
                expect_true(5, wb_cyc === 1'b0, "cyc still high in the cycle after ack");
            end

            compare_value(2, "fetch_pc", fetch_pc, exp_pc);
            if (fetch_pc !== exp_pc) begin
                exp_pc = fetch_pc; // follow the dut from here on
            end
            model_hit = line_held(exp_pc);
            compare_value(4, "fetch_valid", 32'(fetch_valid), 32'(model_hit));
            if (fetch_valid) begin
                compare_value(1, "fetch_inst", fetch_inst, word_at(exp_pc));
                compare_value(1, "fetch_npc", fetch_npc, exp_pc + 32'd4);
            end
            if (have_prev && prev_hold) begin
                compare_value(3, "fetch_pc", fetch_pc, prev_pc);
                if (prev_valid && fetch_valid) begin
                    compare_value(3, "fetch_inst", fetch_inst, prev_inst);
                end
            end

            // a new bus cycle must belong to the line that just missed
            if (wb_cyc && !prev_cyc) begin
                if (first_bus) begin
                    compare_value(0, "wb_adr", wb_adr, line_of(reset_pc));
                    first_bus = 1'b0;
                end
                expect_true(4, !line_held(wb_adr),
                            "bus cycle started for a line already in the cache");
                expect_true(4, have_prev && !prev_hit, "bus cycle started without a miss");
                compare_value(4, "wb_adr", wb_adr, line_of(prev_pc));
            end

            req_vec             = '0;
            req_vec[sel_branch] = branch_req;
            req_vec[sel_rob]    = rob_req;
            req_vec[sel_pred]   = pred_req;
            req_vec[sel_seq]    = model_hit && !decode_stall; // fetch accepted
            if (req_vec[sel_branch]) begin
                next_pc = branch_pc;
            end else if (req_vec[sel_rob]) begin
                next_pc = rob_pc;
            end else if (req_vec[sel_pred]) begin
                next_pc = pred_pc;
            end else if (req_vec[sel_seq]) begin
                next_pc = exp_pc + 32'd4;
            end else begin
                next_pc = exp_pc;
            end

            prev_pc    = exp_pc;
            prev_inst  = fetch_inst;
            prev_valid = fetch_valid;
            prev_hit   = model_hit;
            prev_hold  = decode_stall && !branch_req && !rob_req && !pred_req;
            prev_cyc   = wb_cyc;
            prev_ack   = wb_cyc && wb_ack;
            prev_adr   = wb_adr;
            have_prev  = 1'b1;
            exp_pc     = next_pc;
            if (wb_cyc && wb_ack) begin // line lands in the cache at this edge
                model_valid[index_of(wb_adr)] = 1'b1;
                model_line[index_of(wb_adr)]  = line_of(wb_adr);
            end
        end
    end

    initial begin : run_test
        int total_checks;
        int total_errors;
        reset        <= 1'b1;
        branch_pc    <= '0;
        branch_req   <= 1'b0;
        rob_pc       <= '0;
        rob_req      <= 1'b0;
        pred_pc      <= '0;
        pred_req     <= 1'b0;
        decode_stall <= 1'b0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        repeat (num_cycles) begin
            @(posedge clock);
            drive_random_inputs();
        end
        @(posedge clock);
        total_checks = 0;
        total_errors = 0;
        for (int b = 0; b < num_behaviors; b++) begin
            if (checks[b] == 0) begin
                $display("%s: no checks ran", behavior_name(b));
                errors[b]++;
            end
            $display("%s: %0d checks, %0d errors", behavior_name(b), checks[b], errors[b]);
            total_checks += checks[b];
            total_errors += errors[b];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((reset_cycles + num_cycles + margin) * clock_period);
        $display("watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/wb_memory_model.sv
`default_nettype none

// wishbone classic read slave
// every word holds its own byte address xor 32'h5a5a_0000
module wb_memory_model import fetch_pkg::*; #(
    parameter logic [31:0] seed = 32'h0000_0001  // ack delay stream
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 wb_cyc,
    input  wire logic                 wb_stb,
    input  wire logic [xlen-1:0]      wb_adr,
    output logic      [line_bits-1:0] wb_dat_o,
    output logic                      wb_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] lfsr_state = seed;
    logic [1:0]  wait_left;   // cycles left before ack
    logic        in_transfer; // delay already drawn for this cycle

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // lower word in bits 31:0
    function automatic logic [line_bits-1:0] line_at(input logic [xlen-1:0] base);
        return {(base + 32'd4) ^ 32'h5a5a_0000, base ^ 32'h5a5a_0000};
    endfunction

    always @(posedge clock) begin : respond
        logic [31:0]     draw;
        logic [xlen-1:0] base;
        base = {wb_adr[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}};
        if (reset) begin
            wb_ack      <= 1'b0;
            wb_dat_o    <= '0;
            in_transfer <= 1'b0;
            wait_left   <= '0;
        end else begin
            wb_ack <= 1'b0; // single cycle ack
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!in_transfer) begin
                    take_bits(2, draw); // 1 to 4 cycles in total
                    if (draw[1:0] == 2'd0) begin
                        wb_ack   <= 1'b1;
                        wb_dat_o <= line_at(base);
                    end else begin
                        in_transfer <= 1'b1;
                        wait_left   <= draw[1:0];
                    end
                end else if (wait_left == 2'd1) begin
                    in_transfer <= 1'b0;
                    wb_ack      <= 1'b1;
                    wb_dat_o    <= line_at(base);
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
